/* files.f */
verilog/lsu_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_ctrl_fsm.sv
verilog/lsu_top.sv
testbench/lsu_bus_model.sv
testbench/lsu_assert.sv
testbench/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module lsu_tb -Mdir obj_dir

./obj_dir/Vlsu_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* testbench/lsu_assert.sv */
/*
 * bus handshake and response rules bound into the control FSM
 */

`timescale 1ns/1ns

module lsu_assert (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 lsu_req_i,
  input lsu_pkg::bus_word_t   lsu_addr_i,
  input logic                 busy_i,
  input logic                 data_req_i,
  input logic                 data_gnt_i,
  input lsu_pkg::bus_word_t   data_addr_i,
  input logic                 resp_valid_i,
  input lsu_pkg::lsu_state_e  state_i
);

  import lsu_pkg::*;

  // word of the core address, taken with the strobe
  logic [31:2] word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (lsu_req_i && !busy_i) begin
      word_q <= lsu_addr_i[31:2];
    end
  end

  // core strobes only while the unit is free
  no_strobe_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> !busy_i)
    else $error("core strobe while the unit is busy");

  // an ungranted request keeps its address
  addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i)))
    else $error("bus request dropped or address changed before grant");

  // bus address is the word of the access or the word after it
  word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i |-> ((data_addr_i[1:0] == 2'b00) &&
                    ((data_addr_i[31:2] == word_q) ||
                     (data_addr_i[31:2] == word_q + 30'd1))))
    else $error("bus address is not the aligned word of the access");

  // the pulse ends the access so the unit is idle in the next cycle
  resp_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> (state_i == ST_IDLE))
    else $error("response pulse did not end the access");

endmodule

bind lsu_ctrl_fsm lsu_assert u_lsu_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .lsu_req_i    (lsu_req_i),
  .lsu_addr_i   (lsu_addr_i),
  .busy_i       (busy_o),
  .data_req_i   (data_req_o),
  .data_gnt_i   (data_gnt_i),
  .data_addr_i  (data_addr_o),
  .resp_valid_i (resp_valid_o),
  .state_i      (state_q)
);

/* testbench/lsu_bus_model.sv */
/*
 * memory bus responder for the load/store unit testbench
 * byte memory with random grant and response delays and one error word
 */

`timescale 1ns/1ns

module lsu_bus_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  // fresh random word every cycle
  input  logic [31:0] rand_i,
  // word index that answers with an error
  input  logic        err_en_i,
  input  logic [5:0]  err_word_i,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,
  output logic        data_err_o
);

  logic [7:0]  mem [256];

  // granted requests, oldest first
  logic [5:0]  word_q [$];
  logic        we_q [$];
  logic [3:0]  be_q [$];
  logic [31:0] wdata_q [$];

  logic        gnt_armed;
  logic [1:0]  gnt_wait;
  logic        resp_armed;
  logic [1:0]  resp_wait;

  initial begin
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    data_err_o    = 1'b0;
    gnt_armed     = 1'b0;
    gnt_wait      = '0;
    resp_armed    = 1'b0;
    resp_wait     = '0;
    // fill depends on the whole byte address
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'ha5;
    end
  end

  always @(negedge clk_i) begin : drive_bus
    logic [5:0]  cur_word;
    logic        cur_we;
    logic [3:0]  cur_be;
    logic [31:0] cur_wdata;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_err_o    = 1'b0;
    if (!rst_ni) begin
      gnt_armed  = 1'b0;
      resp_armed = 1'b0;
      word_q.delete();
      we_q.delete();
      be_q.delete();
      wdata_q.delete();
    end else begin
      ////////////////////////////////////////////////
      // responses, in grant order
      ////////////////////////////////////////////////
      if (word_q.size() != 0) begin
        if (!resp_armed) begin
          resp_wait  = rand_i[29:28];
          resp_armed = 1'b1;
        end
        if (resp_wait != 2'd0) begin
          resp_wait = resp_wait - 2'd1;
        end else begin
          cur_word      = word_q.pop_front();
          cur_we        = we_q.pop_front();
          cur_be        = be_q.pop_front();
          cur_wdata     = wdata_q.pop_front();
          resp_armed    = 1'b0;
          data_rvalid_o = 1'b1;
          data_err_o    = err_en_i && (cur_word == err_word_i);
          data_rdata_o  = '0;
          // an erroring word is neither written nor read
          for (int l = 0; l < 4; l++) begin
            if (!data_err_o && cur_we && cur_be[l]) begin
              mem[{cur_word, 2'(l)}] = cur_wdata[8*l +: 8];
            end
            if (!data_err_o) begin
              data_rdata_o[8*l +: 8] = mem[{cur_word, 2'(l)}];
            end
          end
        end
      end
      ////////////////////////////////////////////////
      // grants after a random wait
      ////////////////////////////////////////////////
      if (data_req_i) begin
        if (!gnt_armed) begin
          gnt_wait  = rand_i[31:30];
          gnt_armed = 1'b1;
        end
        if (gnt_wait != 2'd0) begin
          gnt_wait = gnt_wait - 2'd1;
        end else begin
          // taken at the next rising edge, answered one cycle later at the earliest
          data_gnt_o = 1'b1;
          gnt_armed  = 1'b0;
          word_q.push_back(data_addr_i[7:2]);
          we_q.push_back(data_we_i);
          be_q.push_back(data_be_i);
          wdata_q.push_back(data_wdata_i);
        end
      end
    end
  end

endmodule

/* testbench/lsu_tb.sv */
/*
 * load/store unit testbench
 * directed and random accesses checked against a reference memory
 * under random bus timing and injected bus errors
 */

`timescale 1ns/1ns

module lsu_tb;

  import lsu_pkg::*;

  localparam logic [31:0] SEED            = 32'h0577_b9dd;
  // every size at every offset with one store and two loads each
  localparam int          N_DIRECTED      = 36;
  localparam int          N_RANDOM        = 300;
  localparam int          N_ACCESS        = N_DIRECTED + N_RANDOM;
  localparam int          WATCHDOG_CYCLES = 16 + N_ACCESS * 40;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_type_e   lsu_type_i;
  bus_word_t   lsu_addr_i, lsu_wdata_i;
  logic        busy_o, lsu_resp_valid_o, lsu_err_o;
  bus_word_t   lsu_rdata_o;
  logic        data_req_o, data_we_o;
  bus_word_t   data_addr_o, data_wdata_o;
  byte_en_t    data_be_o;
  logic        data_gnt_i, data_rvalid_i, data_err_i;
  bus_word_t   data_rdata_i;

  logic [31:0] stim_seed;
  logic [31:0] bus_rand;
  logic        err_en;
  logic [5:0]  err_word;
  logic [7:0]  ref_mem [256];
  // expected response per access as {load, err, data}
  logic [33:0] exp_mem [N_ACCESS];
  int          sent;
  int          resp_count;
  int          data_errors;
  int          flag_errors;
  int          pulse_errors;
  int          state_errors;

  lsu_top lsu_top_inst (.*);

  lsu_bus_model u_bus_model (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rand_i        (bus_rand),
    .err_en_i      (err_en),
    .err_word_i    (err_word),
    .data_req_i    (data_req_o),
    .data_addr_i   (data_addr_o),
    .data_we_i     (data_we_o),
    .data_be_i     (data_be_o),
    .data_wdata_i  (data_wdata_o),
    .data_gnt_o    (data_gnt_i),
    .data_rvalid_o (data_rvalid_i),
    .data_rdata_o  (data_rdata_i),
    .data_err_o    (data_err_i)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    bus_rand <= lcg_next(bus_rand);
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic lsu_type_e pick_type(input logic [1:0] k);
    return (k == 2'd0) ? LSU_WORD : (k == 2'd1) ? LSU_HALF : LSU_BYTE;
  endfunction

  function automatic int size_of(input lsu_type_e t);
    return (t == LSU_WORD) ? 4 : (t == LSU_HALF) ? 2 : 1;
  endfunction

  // error when the error word is one that the access touches
  function automatic logic ref_err(input logic [7:0] a, input lsu_type_e t);
    logic [5:0] next_word;
    next_word = a[7:2] + 6'd1;
    return err_en && ((a[7:2] == err_word) ||
                      ((int'(a[1:0]) + size_of(t) > 4) && (next_word == err_word)));
  endfunction

  // little-endian field at a extended from its top bit
  function automatic logic [31:0] ref_load(input logic [7:0] a, input lsu_type_e t,
                                           input logic sx);
    logic [31:0] v;
    int          n;
    n = size_of(t);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[a + 8'(i)];
    end
    for (int i = n; i < 4; i++) begin
      v[8*i +: 8] = {8{sx & v[8*n-1]}};
    end
    return v;
  endfunction

  task automatic draw_rand(output logic [31:0] r);
    stim_seed = lcg_next(stim_seed);
    r = stim_seed;
  endtask

  // called on a falling edge with the unit idle and returns once answered
  task automatic run_access(input logic we, input lsu_type_e t, input logic sx,
                            input logic [31:0] a, input logic [31:0] d);
    logic [7:0] b;
    exp_mem[sent] = {~we, ref_err(a[7:0], t), we ? 32'h0 : ref_load(a[7:0], t, sx)};
    for (int i = 0; i < size_of(t); i++) begin
      b = a[7:0] + 8'(i);
      if (we && !(err_en && (b[7:2] == err_word))) begin
        ref_mem[b] = d[8*i +: 8];
      end
    end
    lsu_we_i       = we;
    lsu_type_i     = t;
    lsu_sign_ext_i = sx;
    lsu_addr_i     = a;
    lsu_wdata_i    = d;
    lsu_req_i      = 1'b1;
    sent++;
    @(negedge clk_i);
    lsu_req_i = 1'b0;
    while (resp_count != sent) begin
      // busy from the cycle after the strobe until the response
      assert (busy_o) else begin
        state_errors++;
        $display("error %0t: busy low while access %0d is outstanding",
                 $time, sent - 1);
      end
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    lsu_type_e   t;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = LSU_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    err_en         = 1'b0;
    err_word       = '0;
    stim_seed      = SEED;
    bus_rand       = ~SEED;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'(i) ^ 8'ha5;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    // nothing moves before the first strobe
    assert (!data_req_o && !busy_o && !lsu_resp_valid_o && !lsu_err_o) else begin
      state_errors++;
      $display("error %0t: control outputs are not low after reset", $time);
    end

    // aligned and split cases where the field top bit alternates with the offset
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 3; k++) begin
        t = pick_type(2'(k));
        a = 32'h0000_0040 + 32'(16 * (off * 3 + k) + off);
        draw_rand(d);
        d[7]  = off[0];
        d[15] = off[0];
        d[31] = off[0];
        run_access(1'b1, t, 1'b0, a, d);
        run_access(1'b0, t, 1'b0, a, d);
        run_access(1'b0, t, 1'b1, a, d);
      end
    end

    // random accesses where one in eight hits an error on either part
    for (int n = 0; n < N_RANDOM; n++) begin
      draw_rand(r);
      draw_rand(a);
      draw_rand(d);
      a        = {a[15:0], a[31:16]};
      t        = pick_type(r[21:20]);
      err_en   = (r[24:22] == 3'd0);
      err_word = a[7:2] + {5'd0, r[25]};
      run_access(r[26], t, r[27], a, d);
    end
    err_en = 1'b0;

    repeat (4) @(negedge clk_i);
    assert (resp_count == sent) else begin
      state_errors++;
      $display("response count %0d does not match access count %0d", resp_count, sent);
    end
    // only enabled lanes may have changed
    for (int i = 0; i < 256; i++) begin
      assert (u_bus_model.mem[i] == ref_mem[i]) else begin
        state_errors++;
        $display("error %0t: memory byte %02h is %02h, expected %02h",
                 $time, i, u_bus_model.mem[i], ref_mem[i]);
      end
    end

    $display("accesses %0d, data errors %0d, flag errors %0d, pulse errors %0d, state errors %0d",
             sent, data_errors, flag_errors, pulse_errors, state_errors);
    if (data_errors + flag_errors + pulse_errors + state_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // response check
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : compare
    logic [33:0] e;
    if (rst_ni && lsu_resp_valid_o) begin
      assert (resp_count < sent) else begin
        pulse_errors++;
        $display("response pulse at %0t without an outstanding access", $time);
      end
      if (resp_count < sent) begin
        e = exp_mem[resp_count];
        assert (lsu_err_o == e[32]) else begin
          flag_errors++;
          $display("error %0t: access %0d error flag %0b, expected %0b",
                   $time, resp_count, lsu_err_o, e[32]);
        end
        // data only counts for loads that did not fail
        assert (!e[33] || e[32] || (lsu_rdata_o == e[31:0])) else begin
          data_errors++;
          $display("error %0t: access %0d load data %08h, expected %08h",
                   $time, resp_count, lsu_rdata_o, e[31:0]);
        end
      end
      resp_count++;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* verilog/lsu_ctrl_fsm.sv */
/*
 * load/store control
 * latches the core request, splits misaligned accesses into two word
 * requests and tracks grants, responses and bus errors
 */

`timescale 1ns/1ns

module lsu_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request strobe and its fields
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  lsu_pkg::lsu_type_e    lsu_type_i,
  input  logic                  lsu_sign_ext_i,
  input  lsu_pkg::bus_word_t    lsu_addr_i,
  input  lsu_pkg::bus_word_t    lsu_wdata_i,
  // bus handshake
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  output logic                  data_req_o,
  output lsu_pkg::bus_word_t    data_addr_o,
  output logic                  data_we_o,
  // latched request towards the align blocks
  output lsu_pkg::lsu_type_e    type_o,
  output lsu_pkg::byte_offset_t offset_o,
  output logic                  sign_ext_o,
  output lsu_pkg::bus_word_t    wdata_o,
  output logic                  second_part_o,
  output logic                  first_capture_o,
  // response towards the core
  output logic                  resp_valid_o,
  output logic                  err_o,
  output logic                  busy_o
);

  import lsu_pkg::*;

  lsu_state_e state_q, state_d;

  // latched request
  bus_word_t  addr_q;
  bus_word_t  wdata_q;
  lsu_type_e  type_q;
  logic       we_q;
  logic       sign_ext_q;

  logic       req_accept;
  logic       split_access;
  logic       second_part_q;
  // error seen on the first part
  logic       err_q;
  bus_word_t  addr_aligned;

  // strobes are only legal in idle
  assign req_accept = lsu_req_i & (state_q == ST_IDLE);

  // misaligned word, or half word crossing into the next word
  assign split_access = ((lsu_type_i == LSU_WORD) && (lsu_addr_i[1:0] != 2'b00)) ||
                        ((lsu_type_i == LSU_HALF) && (lsu_addr_i[1:0] == 2'b11));

  //////////////////////////////////////////////////
  // request latch
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q     <= LSU_WORD;
      we_q       <= 1'b0;
      sign_ext_q <= 1'b0;
    end else if (req_accept) begin
      type_q     <= lsu_type_i;
      we_q       <= lsu_we_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    data_req_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        // request goes out the cycle after the strobe
        if (lsu_req_i) begin
          state_d = split_access ? ST_WAIT_GNT_MIS : ST_WAIT_GNT;
        end
      end

      ST_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID_MIS;
        end
      end

      ST_WAIT_RVALID_MIS: begin
        // second request overlaps the outstanding first response
        data_req_o = 1'b1;
        if (data_rvalid_i && data_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end else if (data_rvalid_i) begin
          state_d = ST_WAIT_GNT;
        end else if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      ST_WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      ST_WAIT_RVALID_MIS_GNTS_DONE: begin
        // responses come in order, so this one is the first part
        if (data_rvalid_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      ST_WAIT_RVALID: begin
        if (data_rvalid_i) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // first response of a split access arrives in one of the _MIS states
  assign first_capture_o = data_rvalid_i & ~we_q &
                           ((state_q == ST_WAIT_RVALID_MIS) ||
                            (state_q == ST_WAIT_RVALID_MIS_GNTS_DONE));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_IDLE;
      second_part_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      state_q <= state_d;
      // second part starts with the first grant
      if (req_accept) begin
        second_part_q <= 1'b0;
      end else if ((state_q == ST_WAIT_GNT_MIS) && data_gnt_i) begin
        second_part_q <= 1'b1;
      end
      // error of the first part is kept until the final response
      if (req_accept) begin
        err_q <= 1'b0;
      end else if (data_rvalid_i && data_err_i) begin
        err_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign addr_aligned = {addr_q[31:2], 2'b00};
  // next word for the second part
  assign data_addr_o  = second_part_q ? addr_aligned + bus_word_t'(BYTES_PER_WORD)
                                      : addr_aligned;
  assign data_we_o    = we_q;

  assign type_o        = type_q;
  assign offset_o      = addr_q[1:0];
  assign sign_ext_o    = sign_ext_q;
  assign wdata_o       = wdata_q;
  assign second_part_o = second_part_q;

  // final response, same cycle as the last rvalid
  assign resp_valid_o = data_rvalid_i & (state_q == ST_WAIT_RVALID);
  assign err_o        = resp_valid_o & (err_q | data_err_i);
  assign busy_o       = (state_q != ST_IDLE);

endmodule

/* verilog/lsu_load_align.sv */
/*
 * load alignment
 * keeps the first response of a split load, joins it with the final
 * response and extends the selected field to 32 bits
 */

`timescale 1ns/1ns

module lsu_load_align (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  first_capture_i,
  input  lsu_pkg::lsu_type_e    type_i,
  input  lsu_pkg::byte_offset_t offset_i,
  input  logic                  sign_ext_i,
  input  lsu_pkg::bus_word_t    rdata_i,
  output lsu_pkg::bus_word_t    rdata_o
);

  import lsu_pkg::*;

  // upper three bytes of the first response
  logic [31:8] rdata_q;

  // offset minus one, selects the window in the joined data
  byte_offset_t offset_m1;
  // the access straddles a word boundary
  logic         use_joined;
  // second response above the kept bytes
  logic [55:0]  joined;
  logic [55:0]  joined_shift;
  bus_word_t    single_shift;
  // accessed field moved down to lane 0
  bus_word_t    aligned;
  logic         sign_h;
  logic         sign_b;

  //////////////////////////////////////////////////
  // first part register
  //////////////////////////////////////////////////

  // lane 0 of the first response never belongs to a split access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (first_capture_i) begin
      rdata_q <= rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  // same split rule as the FSM, seen from the latched request
  assign use_joined = ((type_i == LSU_WORD) && (offset_i != 2'b00)) ||
                      ((type_i == LSU_HALF) && (offset_i == 2'b11));

  assign offset_m1 = offset_i - 2'd1;
  assign joined    = {rdata_i, rdata_q};

  // kept bytes start at lane 1, so shift by one byte less than the offset
  // offset 1 gives {rdata[7:0], first[31:8]}
  assign joined_shift = joined >> {offset_m1, 3'b000};

  // field lies wholly inside the current response
  assign single_shift = rdata_i >> {offset_i, 3'b000};

  assign aligned = use_joined ? joined_shift[31:0] : single_shift;

  //////////////////////////////////////////////////
  // sign and zero extension
  //////////////////////////////////////////////////

  // top bit of the field, only when the core asked for sign extension
  assign sign_h = sign_ext_i & aligned[15];
  assign sign_b = sign_ext_i & aligned[7];

  always_comb begin
    unique case (type_i)
      LSU_WORD: rdata_o = aligned;
      LSU_HALF: rdata_o = {{16{sign_h}}, aligned[15:0]};
      LSU_BYTE: rdata_o = {{24{sign_b}}, aligned[7:0]};
      default:  rdata_o = aligned;
    endcase
  end

endmodule

/* verilog/lsu_pkg.sv */
/*
 * load/store unit shared definitions
 * access size, bus word types and the control FSM state encoding
 */

package lsu_pkg;

  // bytes in one bus word, fixes the lane logic to 32 bits
  parameter int unsigned BYTES_PER_WORD = 4;

  // one bus data or address word
  typedef logic [31:0] bus_word_t;

  // one enable per byte lane
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

  // byte position of an address inside its word
  typedef logic [1:0] byte_offset_t;

  // access size as sent by the core
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // control FSM states
  // the _MIS states belong to the first part of a split access
  typedef enum logic [2:0] {
    ST_IDLE                      = 3'd0,
    // first request of a split access waits for grant
    ST_WAIT_GNT_MIS              = 3'd1,
    // first response outstanding, second request on the bus
    ST_WAIT_RVALID_MIS           = 3'd2,
    ST_WAIT_GNT                  = 3'd3,
    // both parts granted, first response still outstanding
    ST_WAIT_RVALID_MIS_GNTS_DONE = 3'd4,
    ST_WAIT_RVALID               = 3'd5
  } lsu_state_e;

endpackage

/* verilog/lsu_store_align.sv */
/*
 * store alignment
 * byte enables and store data lane rotation for either part of an access
 */

`timescale 1ns/1ns

module lsu_store_align (
  input  lsu_pkg::lsu_type_e    type_i,
  input  lsu_pkg::byte_offset_t offset_i,
  input  logic                  second_part_i,
  input  lsu_pkg::bus_word_t    wdata_i,
  output lsu_pkg::byte_en_t     be_o,
  output lsu_pkg::bus_word_t    wdata_o
);

  import lsu_pkg::*;

  // lanes covered by the access before shifting to the offset
  byte_en_t size_mask;
  // enables over two consecutive words, low half is the first part
  logic [2*BYTES_PER_WORD-1:0] be_wide;
  // write data doubled so a left shift gives a rotation
  logic [2*$bits(bus_word_t)-1:0] wdata_wide;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    unique case (type_i)
      LSU_WORD: size_mask = 4'b1111;
      LSU_HALF: size_mask = 4'b0011;
      LSU_BYTE: size_mask = 4'b0001;
      default:  size_mask = 4'b1111;
    endcase
  end

  // lanes that run past lane 3 spill into the upper nibble
  assign be_wide = {{BYTES_PER_WORD{1'b0}}, size_mask} << offset_i;

  // first part takes lanes from the offset up to lane 3,
  // second part the low lanes that were cut off
  assign be_o = second_part_i ? be_wide[2*BYTES_PER_WORD-1:BYTES_PER_WORD]
                              : be_wide[BYTES_PER_WORD-1:0];

  //////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////

  // rotate left by offset bytes
  // offset 1 gives {wdata[23:0], wdata[31:24]}
  assign wdata_wide = {wdata_i, wdata_i} << {offset_i, 3'b000};

  // bytes shifted out of lane 3 wrap to lane 0, where the second
  // part of a split store picks them up, so both parts share this word
  assign wdata_o = wdata_wide[2*$bits(bus_word_t)-1:$bits(bus_word_t)];

endmodule

/* verilog/lsu_top.sv */
/*
 * load/store unit top level
 * joins the control FSM and the store and load alignment blocks
 */

`timescale 1ns/1ns

module lsu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core side
  input  logic                lsu_req_i,
  input  logic                lsu_we_i,
  input  lsu_pkg::lsu_type_e  lsu_type_i,
  input  logic                lsu_sign_ext_i,
  input  lsu_pkg::bus_word_t  lsu_addr_i,
  input  lsu_pkg::bus_word_t  lsu_wdata_i,
  output logic                busy_o,
  output logic                lsu_resp_valid_o,
  output lsu_pkg::bus_word_t  lsu_rdata_o,
  output logic                lsu_err_o,
  // bus side
  output logic                data_req_o,
  output lsu_pkg::bus_word_t  data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::byte_en_t   data_be_o,
  output lsu_pkg::bus_word_t  data_wdata_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  lsu_pkg::bus_word_t  data_rdata_i,
  input  logic                data_err_i
);

  import lsu_pkg::*;

  // latched request fields from the FSM
  lsu_type_e    acc_type;
  byte_offset_t acc_offset;
  logic         acc_sign_ext;
  bus_word_t    acc_wdata;
  logic         second_part;
  logic         first_capture;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req_i),
    .lsu_we_i        (lsu_we_i),
    .lsu_type_i      (lsu_type_i),
    .lsu_sign_ext_i  (lsu_sign_ext_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .type_o          (acc_type),
    .offset_o        (acc_offset),
    .sign_ext_o      (acc_sign_ext),
    .wdata_o         (acc_wdata),
    .second_part_o   (second_part),
    .first_capture_o (first_capture),
    .resp_valid_o    (lsu_resp_valid_o),
    .err_o           (lsu_err_o),
    .busy_o          (busy_o)
  );

  // bus fields follow the latched request with no delay
  lsu_store_align u_store_align (
    .type_i        (acc_type),
    .offset_i      (acc_offset),
    .second_part_i (second_part),
    .wdata_i       (acc_wdata),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .first_capture_i (first_capture),
    .type_i          (acc_type),
    .offset_i        (acc_offset),
    .sign_ext_i      (acc_sign_ext),
    .rdata_i         (data_rdata_i),
    .rdata_o         (lsu_rdata_o)
  );

endmodule
